/* chiplet_types_pkg.sv */
package chiplet_types_pkg;

    localparam int FLIT_W = 32;
    localparam int SIZE_W = 8;
    localparam int CRC_W  = 32;

    typedef enum logic [3:0] {
        DATA    = 4'h1,
        CONTROL = 4'h2
    } flit_format_e;

    // Header layout, format in the top nibble.
    typedef struct packed {
        flit_format_e      format;
        logic [SIZE_W-1:0] size;  // Number of payload flits that follow.
        logic [3:0]        dest;
        logic [15:0]       rsvd;
    } flit_hdr_t;

    // A decoded flit is a header or a plain payload word.
    typedef union packed {
        flit_hdr_t         hdr;
        logic [FLIT_W-1:0] payload;
    } flit_u;

    // CRC-32 is shifted MSB first with no final XOR.
    localparam logic [CRC_W-1:0] CRC_POLY = 32'h04C1_1DB7;
    localparam logic [CRC_W-1:0] CRC_INIT = 32'hFFFF_FFFF;

endpackage

/* compile.f */
+incdir+.
phy_types_pkg.sv
chiplet_types_pkg.sv
flit_decoder_8b10b.sv
crc32_engine.sv
phy_rx_manager.sv
phy_rx_top.sv
tb_clock_gen.sv
phy_rx_tb.sv

/* crc32_engine.sv */
`timescale 1ns/1ps

module crc32_engine
    import chiplet_types_pkg::*;
#(
    parameter int UNROLL_FACTOR = 8
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             crc_clear,
    input  logic             crc_update,
    input  logic [CRC_W-1:0] crc_in,
    output logic [CRC_W-1:0] crc_out,
    output logic             crc_busy,
    output logic             crc_done
);

    localparam int STEPS = CRC_W / UNROLL_FACTOR;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic [CRC_W-1:0] data_sr;
    logic [CNT_W-1:0] step_cnt;

    // Feeds UNROLL_FACTOR message bits into the register, MSB first.
    function automatic logic [CRC_W-1:0] crc_chunk(input logic [CRC_W-1:0] crc,
                                                   input logic [UNROLL_FACTOR-1:0] bits);
        logic [CRC_W-1:0] c;
        logic             fb;
        c = crc;
        for (int i = UNROLL_FACTOR - 1; i >= 0; i--) begin
            fb = c[CRC_W-1] ^ bits[i];
            c  = {c[CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
        end
        return c;
    endfunction

    // The first chunk is taken straight from crc_in on the update edge.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            crc_out  <= CRC_INIT;
            crc_busy <= 1'b0;
            crc_done <= 1'b0;
            step_cnt <= '0;
        end else if (crc_clear) begin
            crc_out  <= CRC_INIT;  // Also aborts a pass in flight.
            crc_busy <= 1'b0;
            crc_done <= 1'b0;
            step_cnt <= '0;
        end else if (crc_update) begin
            crc_out  <= crc_chunk(crc_out, crc_in[CRC_W-1 -: UNROLL_FACTOR]);
            crc_busy <= 1'b1;
            crc_done <= (STEPS == 1);
            step_cnt <= CNT_W'(1);
        end else if (crc_done) begin
            crc_busy <= 1'b0;
            crc_done <= 1'b0;
        end else if (crc_busy) begin
            crc_out  <= crc_chunk(crc_out, data_sr[CRC_W-1 -: UNROLL_FACTOR]);
            crc_done <= (step_cnt == CNT_W'(STEPS - 1));
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (crc_update) begin
            data_sr <= crc_in << UNROLL_FACTOR;
        end else if (crc_busy) begin
            data_sr <= data_sr << UNROLL_FACTOR;
        end
    end

    a_no_update_busy : assert property (@(posedge CLK) disable iff (!nRST)
        crc_busy |-> !crc_update)
        else $error("CRC update requested during a pass.");

endmodule

/* flit_decoder_8b10b.sv */
`timescale 1ns/1ps

module flit_decoder_8b10b
    import phy_types_pkg::*, chiplet_types_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic [ENC_FLIT_W-1:0] enc_flit,
    input  logic                  enc_valid,
    output flit_u                 flit,
    output logic                  flit_valid,
    output logic                  sym_err
);

    logic [FLIT_W-1:0] dec_word;
    logic              bad_sym;
    logic              is_comma;
    logic [SYM_W-1:0]  sym;
    logic [5:0]        lo;
    logic [3:0]        hi;

    // Returns {valid, EDCBA}. Both disparities decode to the same value.
    function automatic logic [5:0] dec_5b6b(input logic [SUB6_W-1:0] abcdei);
        logic [5:0] r;
        case (abcdei)
            6'b100111, 6'b011000: r = {1'b1, 5'd0};
            6'b011101, 6'b100010: r = {1'b1, 5'd1};
            6'b101101, 6'b010010: r = {1'b1, 5'd2};
            6'b110001:            r = {1'b1, 5'd3};
            6'b110101, 6'b001010: r = {1'b1, 5'd4};
            6'b101001:            r = {1'b1, 5'd5};
            6'b011001:            r = {1'b1, 5'd6};
            6'b111000, 6'b000111: r = {1'b1, 5'd7};
            6'b111001, 6'b000110: r = {1'b1, 5'd8};
            6'b100101:            r = {1'b1, 5'd9};
            6'b010101:            r = {1'b1, 5'd10};
            6'b110100:            r = {1'b1, 5'd11};
            6'b001101:            r = {1'b1, 5'd12};
            6'b101100:            r = {1'b1, 5'd13};
            6'b011100:            r = {1'b1, 5'd14};
            6'b010111, 6'b101000: r = {1'b1, 5'd15};
            6'b011011, 6'b100100: r = {1'b1, 5'd16};
            6'b100011:            r = {1'b1, 5'd17};
            6'b010011:            r = {1'b1, 5'd18};
            6'b110010:            r = {1'b1, 5'd19};
            6'b001011:            r = {1'b1, 5'd20};
            6'b101010:            r = {1'b1, 5'd21};
            6'b011010:            r = {1'b1, 5'd22};
            6'b111010, 6'b000101: r = {1'b1, 5'd23};
            6'b110011, 6'b001100: r = {1'b1, 5'd24};
            6'b100110:            r = {1'b1, 5'd25};
            6'b010110:            r = {1'b1, 5'd26};
            6'b110110, 6'b001001: r = {1'b1, 5'd27};
            6'b001110:            r = {1'b1, 5'd28};
            6'b101110, 6'b010001: r = {1'b1, 5'd29};
            6'b011110, 6'b100001: r = {1'b1, 5'd30};
            6'b101011, 6'b010100: r = {1'b1, 5'd31};
            default:              r = 6'b0;  // K28 and the rest are not data.
        endcase
        return r;
    endfunction

    // Returns {valid, HGF}. The alternate D.x.A7 codes are accepted too.
    function automatic logic [3:0] dec_3b4b(input logic [SUB4_W-1:0] fghj);
        logic [3:0] r;
        case (fghj)
            4'b1011, 4'b0100:                   r = {1'b1, 3'd0};
            4'b1001:                            r = {1'b1, 3'd1};
            4'b0101:                            r = {1'b1, 3'd2};
            4'b1100, 4'b0011:                   r = {1'b1, 3'd3};
            4'b1101, 4'b0010:                   r = {1'b1, 3'd4};
            4'b1010:                            r = {1'b1, 3'd5};
            4'b0110:                            r = {1'b1, 3'd6};
            4'b1110, 4'b0001, 4'b0111, 4'b1000: r = {1'b1, 3'd7};
            default:                            r = 4'b0;
        endcase
        return r;
    endfunction

    assign is_comma = (enc_flit[SYM_W-1:0] == K28_5_RDN) ||
                      (enc_flit[SYM_W-1:0] == K28_5_RDP);

    // Symbol i lands in byte i of the flit.
    always_comb begin
        dec_word = '0;
        bad_sym  = 1'b0;
        sym      = '0;
        lo       = '0;
        hi       = '0;
        for (int i = 0; i < SYMS_PER_FLIT; i++) begin
            sym = enc_flit[i*SYM_W +: SYM_W];
            lo  = dec_5b6b(sym[SYM_W-1 -: SUB6_W]);
            hi  = dec_3b4b(sym[SUB4_W-1:0]);
            dec_word[i*SYM_DATA_W +: SYM_DATA_W] = {hi[2:0], lo[4:0]};
            bad_sym = bad_sym | ~(lo[5] & hi[3]);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flit_valid <= 1'b0;
            sym_err    <= 1'b0;
        end else begin
            flit_valid <= enc_valid & ~is_comma & ~bad_sym;
            sym_err    <= enc_valid & ~is_comma & bad_sym;  // Idle flits never report.
        end
    end

    always_ff @(posedge CLK) begin
        if (enc_valid && !is_comma) begin
            flit.payload <= dec_word;
        end
    end

    a_valid_or_err : assert property (@(posedge CLK) disable iff (!nRST)
        !(flit_valid && sym_err))
        else $error("flit_valid and sym_err are high together.");

endmodule

/* phy_rx_manager.sv */
`timescale 1ns/1ps

module phy_rx_manager
    import chiplet_types_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  flit_u             flit,
    input  logic              flit_valid,
    input  logic              sym_err,
    input  logic [CRC_W-1:0]  crc_out,
    input  logic              crc_busy,
    input  logic              crc_done,
    output logic              crc_clear,
    output logic              crc_update,
    output logic [CRC_W-1:0]  crc_in,
    output logic [FLIT_W-1:0] flit_out,
    output logic              flit_strobe,
    output logic              packet_done,
    output logic              crc_ok,
    output logic              err_out
);

    localparam logic [2:0] WAIT_HDR  = 3'd0;
    localparam logic [2:0] RUN_CRC   = 3'd1;
    localparam logic [2:0] WAIT_FLIT = 3'd2;
    localparam logic [2:0] CHECK_CRC = 3'd3;
    localparam logic [2:0] ERR       = 3'd4;

    logic [2:0]        state;
    logic [2:0]        n_state;
    logic [SIZE_W-1:0] size_q;
    logic [SIZE_W-1:0] cnt;
    logic [FLIT_W-1:0] data_q;
    logic              is_hdr;  // The running pass belongs to the header.
    logic              accept;
    logic              overrun;
    logic              load_hdr;
    logic              load_word;
    logic              cnt_inc;
    logic              cnt_clr;

    assign overrun  = flit_valid & crc_busy;
    assign accept   = flit_valid & ~crc_busy;
    assign crc_in   = flit.payload;
    assign flit_out = data_q;

    always_comb begin
        n_state     = state;
        crc_clear   = 1'b0;
        crc_update  = 1'b0;
        flit_strobe = 1'b0;
        packet_done = 1'b0;
        crc_ok      = 1'b0;
        err_out     = 1'b0;
        load_hdr    = 1'b0;
        load_word   = 1'b0;
        cnt_inc     = 1'b0;
        cnt_clr     = 1'b0;
        case (state)
            WAIT_HDR: begin
                if (accept) begin
                    crc_update = 1'b1;
                    load_hdr   = 1'b1;
                    cnt_clr    = 1'b1;
                    n_state    = RUN_CRC;
                end
            end
            RUN_CRC: begin
                if (crc_done) begin
                    flit_strobe = ~is_hdr;  // The header itself is never passed out.
                    cnt_inc     = ~is_hdr;
                    n_state     = WAIT_FLIT;
                end
            end
            WAIT_FLIT: begin
                if (accept) begin
                    load_word = 1'b1;
                    if (cnt == size_q) begin
                        n_state = CHECK_CRC;  // This one is the CRC flit.
                    end else begin
                        crc_update = 1'b1;
                        n_state    = RUN_CRC;
                    end
                end
            end
            CHECK_CRC: begin
                packet_done = 1'b1;
                crc_ok      = (crc_out == data_q);
                crc_clear   = 1'b1;
                cnt_clr     = 1'b1;
                n_state     = WAIT_HDR;
            end
            ERR: begin
                err_out   = 1'b1;
                crc_clear = 1'b1;
                cnt_clr   = 1'b1;
                n_state   = WAIT_HDR;
            end
            default: begin
                n_state = WAIT_HDR;
            end
        endcase
        if (sym_err || overrun) begin
            n_state = ERR;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= WAIT_HDR;
            cnt    <= '0;
            is_hdr <= 1'b0;
        end else begin
            state <= n_state;
            if (cnt_clr) begin
                cnt <= '0;
            end else if (cnt_inc) begin
                cnt <= cnt + 1'b1;
            end
            if (crc_update) begin
                is_hdr <= load_hdr;
            end
        end
    end

    // The word stays put until the next flit, so flit_out is stable under the strobe.
    always_ff @(posedge CLK) begin
        if (load_hdr) begin
            size_q <= flit.hdr.size;
        end
        if (load_word) begin
            data_q <= flit.payload;
        end
    end

    a_done_vs_strobe : assert property (@(posedge CLK) disable iff (!nRST)
        !(packet_done && flit_strobe))
        else $error("packet_done and flit_strobe are high together.");

endmodule

/* tb_8b10b_encode.svh */
`ifndef TB_8B10B_ENCODE_SVH
`define TB_8B10B_ENCODE_SVH

// abcdei codes for D.0 to D.31 at negative running disparity, D.0 in the low six bits.
localparam logic [32*6-1:0] ENC6_RDN = {
    6'b101011, 6'b011110, 6'b101110, 6'b001110, 6'b110110, 6'b010110, 6'b100110, 6'b110011,
    6'b111010, 6'b011010, 6'b101010, 6'b001011, 6'b110010, 6'b010011, 6'b100011, 6'b011011,
    6'b010111, 6'b011100, 6'b101100, 6'b001101, 6'b110100, 6'b010101, 6'b100101, 6'b111001,
    6'b111000, 6'b011001, 6'b101001, 6'b110101, 6'b110001, 6'b101101, 6'b011101, 6'b100111
};

// fghj codes for D.x.0 to D.x.7 at negative running disparity.
localparam logic [8*4-1:0] ENC4_RDN = {
    4'b1110, 4'b0110, 4'b1010, 4'b1101, 4'b1100, 4'b0101, 4'b1001, 4'b1011
};

// Returns {running disparity after the symbol, abcdei, fghj}.
function automatic logic [SYM_W:0] enc_data(input logic [7:0] d, input logic rd);
    logic [5:0] s6;
    logic [3:0] s4;
    logic       r;
    logic       a7;
    r  = rd;
    s6 = ENC6_RDN[d[4:0]*6 +: 6];
    if (r && ($countones(s6) != 3 || d[4:0] == 5'd7)) begin
        s6 = ~s6;
    end
    if ($countones(s6) != 3) begin
        r = ~r;  // Unbalanced sub-blocks flip the disparity.
    end
    s4 = ENC4_RDN[d[7:5]*4 +: 4];
    a7 = r ? (d[4:0] == 5'd11 || d[4:0] == 5'd13 || d[4:0] == 5'd14)
           : (d[4:0] == 5'd17 || d[4:0] == 5'd18 || d[4:0] == 5'd20);
    if (d[7:5] == 3'd7 && a7) begin
        s4 = 4'b0111;  // D.x.A7 avoids a run of five equal bits.
    end
    if (r && ($countones(s4) != 2 || d[7:5] == 3'd3)) begin
        s4 = ~s4;
    end
    if ($countones(s4) != 2) begin
        r = ~r;
    end
    return {r, s6, s4};
endfunction

// K28.5 always flips the running disparity.
function automatic logic [SYM_W:0] enc_comma(input logic rd);
    return {~rd, rd ? K28_5_RDP : K28_5_RDN};
endfunction

// Folds one word into the CRC, MSB first, with no final XOR.
function automatic logic [31:0] crc32_ref(input logic [31:0] crc, input logic [31:0] word);
    logic [31:0] c;
    c = crc;
    for (int i = 31; i >= 0; i--) begin
        if (c[31] ^ word[i]) begin
            c = {c[30:0], 1'b0} ^ CRC_POLY;
        end else begin
            c = {c[30:0], 1'b0};
        end
    end
    return c;
endfunction

`endif

/* phy_rx_tb.sv */
`timescale 1ns/1ps

module phy_rx_tb
    import phy_types_pkg::*, chiplet_types_pkg::*;
();

    localparam int UNROLL      = 8;
    localparam int GAP         = 32 / UNROLL + 3;
    localparam int MAX_FLITS   = 27 * 28;  // 27 packets of up to 14 flits, each maybe with a comma.
    localparam int WATCHDOG_NS = MAX_FLITS * GAP * 20 + 16 * 20 + 5000;
    localparam int EV_DATA     = 0;
    localparam int EV_DONE     = 1;
    localparam int EV_ERR      = 2;
    localparam int NO_FAULT    = 0;
    localparam int BAD_CRC     = 1;
    localparam int BAD_SYM     = 2;
    localparam int OVERRUN     = 3;
    localparam logic [SYM_W-1:0] INVALID_CODE = 10'b111111_0000;

    logic                  CLK;
    logic                  nRST;
    logic [ENC_FLIT_W-1:0] enc_flit;
    logic                  enc_valid;
    logic [FLIT_W-1:0]     flit_out;
    logic                  flit_strobe;
    logic                  packet_done;
    logic                  crc_ok;
    logic                  err_out;
    logic [31:0]           lfsr = 32'h97a1;
    logic                  run_disp;
    int                    exp_kind[$];
    logic [31:0]           exp_data[$];
    int                    exp_test[$];
    int                    val_errs;
    int                    proto_errs;

    `include "tb_8b10b_encode.svh"

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk (.CLK(CLK), .nRST(nRST));

    phy_rx_top #(.UNROLL_FACTOR(UNROLL)) DUT (
        .CLK(CLK), .nRST(nRST), .enc_flit(enc_flit), .enc_valid(enc_valid),
        .flit_out(flit_out), .flit_strobe(flit_strobe), .packet_done(packet_done),
        .crc_ok(crc_ok), .err_out(err_out)
    );

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [ENC_FLIT_W-1:0] encode_flit(input logic [31:0] w, input bit comma);
        logic [ENC_FLIT_W-1:0] e;
        logic [SYM_W:0]        s;
        for (int i = 0; i < SYMS_PER_FLIT; i++) begin
            s = comma ? enc_comma(run_disp) : enc_data(w[i*8 +: 8], run_disp);
            e[i*SYM_W +: SYM_W] = s[SYM_W-1:0];
            run_disp = s[SYM_W];
        end
        return e;
    endfunction

    function automatic string test_label(input int id);
        case (id)
            1:       return "good_packets";
            2:       return "bad_crc";
            3:       return "comma_idle";
            4:       return "bad_symbol";
            5:       return "overrun";
            default: return "zero_size";
        endcase
    endfunction

    function automatic string pulse_label(input int kind);
        case (kind)
            EV_DATA: return "flit_strobe";
            EV_DONE: return "packet_done";
            default: return "err_out";
        endcase
    endfunction

    task automatic push_expect(input int kind, input logic [31:0] data, input int test);
        exp_kind.push_back(kind);
        exp_data.push_back(data);
        exp_test.push_back(test);
    endtask

    // Called on a falling edge; the next flit goes out gap cycles later.
    task automatic send_flit(input logic [ENC_FLIT_W-1:0] enc, input int gap);
        enc_flit  = enc;
        enc_valid = 1'b1;
        @(negedge CLK);
        enc_valid = 1'b0;
        repeat (gap - 1) @(negedge CLK);
    endtask

    task automatic send_packet(input int test, input int size, input int fault,
                               input int fault_at, input bit commas);
        logic [31:0]           words[$];
        flit_u                 hdr;
        logic [31:0]           crc;
        logic [ENC_FLIT_W-1:0] enc;
        int                    pos;
        hdr.payload    = rand_bits(32);
        hdr.hdr.format = DATA;
        hdr.hdr.size   = SIZE_W'(size);
        words.push_back(hdr.payload);
        for (int i = 0; i < size; i++) begin
            words.push_back(rand_bits(32));
        end
        crc = CRC_INIT;
        foreach (words[i]) begin
            crc = crc32_ref(crc, words[i]);
        end
        if (fault == BAD_CRC) begin
            crc = crc ^ (32'h1 << rand_bits(5));
        end
        words.push_back(crc);
        for (int i = 0; i < words.size(); i++) begin
            enc = encode_flit(words[i], 1'b0);
            if (i == fault_at && fault == BAD_SYM) begin
                pos = rand_bits(2);
                enc[pos*SYM_W +: SYM_W] = INVALID_CODE;
                push_expect(EV_ERR, '0, test);
                send_flit(enc, GAP);
                return;  // The sender abandons the rest of the packet.
            end
            if (i == fault_at && fault == OVERRUN) begin
                push_expect(EV_ERR, '0, test);
                send_flit(enc, 1);
                send_flit(encode_flit(words[i + 1], 1'b0), GAP);
                return;
            end
            if (i == words.size() - 1) begin
                push_expect(EV_DONE, {31'b0, fault != BAD_CRC}, test);
            end else if (i > 0) begin
                push_expect(EV_DATA, words[i], test);
            end
            send_flit(enc, GAP);
            if (commas && rand_bits(1)) begin
                send_flit(encode_flit('0, 1'b1), GAP);
            end
        end
    endtask

    task automatic check_event(input int kind, input logic [31:0] actual);
        bit    ok;
        string what;
        ok = exp_kind.size() != 0 && exp_kind[0] == kind;
        assert (ok) else begin
            $display("Unexpected %s pulse at %0t ns.", pulse_label(kind), $time);
            proto_errs++;
        end
        if (ok) begin
            what = (kind == EV_DATA) ? "flit_out" : "crc_ok";
            assert (kind == EV_ERR || actual == exp_data[0]) else begin
                $display("[ERROR] %s: %s expected %h, actual %h", test_label(exp_test[0]),
                         what, exp_data[0], actual);
                val_errs++;
            end
            void'(exp_kind.pop_front());
            void'(exp_data.pop_front());
            void'(exp_test.pop_front());
        end
    endtask

    // DUT outputs come from registers, so they are read just after the rising edge.
    always begin : compare
        @(posedge CLK);
        #1;
        if (nRST) begin
            if (flit_strobe) begin
                check_event(EV_DATA, flit_out);
            end
            if (packet_done) begin
                check_event(EV_DONE, {31'b0, crc_ok});
            end
            if (err_out) begin
                check_event(EV_ERR, '0);
            end
        end
    end

    initial begin : stimulus
        int size;
        enc_flit   = '0;
        enc_valid  = 1'b0;
        run_disp   = 1'b0;
        val_errs   = 0;
        proto_errs = 0;
        wait (nRST === 1'b1);
        @(negedge CLK);
        for (int p = 0; p < 8; p++) begin
            send_packet(1, rand_bits(4) % 13, NO_FAULT, 0, 1'b0);
        end
        send_packet(2, rand_bits(4) % 13, BAD_CRC, 0, 1'b0);
        send_packet(2, rand_bits(4) % 13, NO_FAULT, 0, 1'b0);
        for (int p = 0; p < 3; p++) begin
            send_packet(3, rand_bits(4) % 13, NO_FAULT, 0, 1'b1);
        end
        for (int p = 0; p < 3; p++) begin
            size = rand_bits(4) % 13;
            send_packet(4, size, BAD_SYM, rand_bits(4) % (size + 2), 1'b0);
            send_packet(4, rand_bits(4) % 13, NO_FAULT, 0, 1'b0);
        end
        for (int p = 0; p < 3; p++) begin
            size = 1 + rand_bits(4) % 12;
            send_packet(5, size, OVERRUN, 1 + rand_bits(4) % size, 1'b0);
            send_packet(5, rand_bits(4) % 13, NO_FAULT, 0, 1'b0);
        end
        for (int p = 0; p < 2; p++) begin
            send_packet(6, 0, NO_FAULT, 0, 1'b0);
        end
        for (int i = 0; i < 200 && exp_kind.size() != 0; i++) begin
            @(posedge CLK);
        end
        repeat (GAP) @(posedge CLK);
        assert (exp_kind.size() == 0) else begin
            $display("%0d expected output pulses never appeared.", exp_kind.size());
            proto_errs++;
        end
        $display("Errors: %0d value mismatches, %0d protocol failures", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns.", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

/* phy_rx_top.sv */
`timescale 1ns/1ps

module phy_rx_top
    import phy_types_pkg::*, chiplet_types_pkg::*;
#(
    parameter int UNROLL_FACTOR = 8
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic [ENC_FLIT_W-1:0] enc_flit,
    input  logic                  enc_valid,
    output logic [FLIT_W-1:0]     flit_out,
    output logic                  flit_strobe,
    output logic                  packet_done,
    output logic                  crc_ok,
    output logic                  err_out
);

    flit_u            flit;
    logic             flit_valid;
    logic             sym_err;
    logic             crc_clear;
    logic             crc_update;
    logic [CRC_W-1:0] crc_in;
    logic [CRC_W-1:0] crc_out;
    logic             crc_busy;
    logic             crc_done;

    flit_decoder_8b10b u_dec (
        .CLK        (CLK),
        .nRST       (nRST),
        .enc_flit   (enc_flit),
        .enc_valid  (enc_valid),
        .flit       (flit),
        .flit_valid (flit_valid),
        .sym_err    (sym_err)
    );

    crc32_engine #(
        .UNROLL_FACTOR (UNROLL_FACTOR)
    ) u_crc (
        .CLK        (CLK),
        .nRST       (nRST),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_in     (crc_in),
        .crc_out    (crc_out),
        .crc_busy   (crc_busy),
        .crc_done   (crc_done)
    );

    phy_rx_manager u_mgr (
        .CLK         (CLK),
        .nRST        (nRST),
        .flit        (flit),
        .flit_valid  (flit_valid),
        .sym_err     (sym_err),
        .crc_out     (crc_out),
        .crc_busy    (crc_busy),
        .crc_done    (crc_done),
        .crc_clear   (crc_clear),
        .crc_update  (crc_update),
        .crc_in      (crc_in),
        .flit_out    (flit_out),
        .flit_strobe (flit_strobe),
        .packet_done (packet_done),
        .crc_ok      (crc_ok),
        .err_out     (err_out)
    );

endmodule

/* phy_types_pkg.sv */
package phy_types_pkg;

    // One symbol is held as {abcdei, fghj}. Bit a sits at bit 9 and j at bit 0.
    localparam int SYM_W         = 10;
    localparam int SYM_DATA_W    = 8;
    localparam int SUB6_W        = 6;  // 5b/6b sub-block, abcdei.
    localparam int SUB4_W        = 4;  // 3b/4b sub-block, fghj.

    localparam int SYMS_PER_FLIT = 4;
    localparam int ENC_FLIT_W    = SYM_W * SYMS_PER_FLIT;

    // K28.5 comma in both running disparities.
    localparam logic [SYM_W-1:0] K28_5_RDN = 10'b001111_1010;
    localparam logic [SYM_W-1:0] K28_5_RDP = 10'b110000_0101;

endpackage

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;  // Released half a cycle before the next rising edge.
    end

endmodule
